/* project.f */
verilog/simd_lane_pkg.sv
verilog/simd_bus_pkg.sv
verilog/vec_addsub.sv
verilog/vec_mul.sv
verilog/vec_shift.sv
verilog/simd_functional_unit.sv
verilog/simd_lane_wb.sv
verilog/simd_lane_top.sv
tests/simd_lane_sva.sv
tests/simd_lane_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SIMD lane testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module simd_lane_tb \
    -f project.f \
    -Mdir obj_dir

./obj_dir/Vsimd_lane_tb

/* tests/simd_lane_tb.sv */
////////////////////
// Testbench for the SIMD lane
// Clock, reset, Wishbone tasks, reference model and checks
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_lane_tb;

localparam int LANE = 3;
localparam simd_lane_pkg::vec_op_e RAND_OPS [14] = '{
    simd_lane_pkg::OP_ADD, simd_lane_pkg::OP_SUB, simd_lane_pkg::OP_MIN,
    simd_lane_pkg::OP_MAX, simd_lane_pkg::OP_SADD, simd_lane_pkg::OP_SADDU,
    simd_lane_pkg::OP_SLL, simd_lane_pkg::OP_SRL, simd_lane_pkg::OP_SRA,
    simd_lane_pkg::OP_AND, simd_lane_pkg::OP_OR, simd_lane_pkg::OP_XOR,
    simd_lane_pkg::OP_MUL, simd_lane_pkg::OP_MACC
};

logic                             clk_i;
logic                             rstn_i;
logic                             wb_cyc_i;
logic                             wb_stb_i;
logic                             wb_we_i;
logic [2:0]                       wb_adr_i;
logic [simd_lane_pkg::DATA_W-1:0] wb_dat_i;
logic [simd_lane_pkg::DATA_W-1:0] wb_dat_o;
logic                             wb_ack_o;

simd_lane_top #(
    .LANE_ID (LANE)
) i_dut (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
);

initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;                  // 4 ns period
end

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
endtask

// Expected {sat, result} built element by element
function automatic logic [64:0] ref_lane(input simd_lane_pkg::vec_op_e op,
                                         input simd_lane_pkg::sew_e sew,
                                         input logic [63:0] a, b, c, input int lane);
    int                 ew;
    int                 ne;
    logic [63:0]        mask, ea, eb, ec, sh, r, res;
    logic signed [63:0] ta, tb;
    logic signed [65:0] ssum, smax, smin;
    logic [65:0]        usum, umax;
    logic               sat;
    ew   = 8 << sew;
    ne   = 64 / ew;
    mask = (ew == 64) ? {64{1'b1}} : ((64'd1 << ew) - 64'd1);
    smax = (66'sd1 <<< (ew - 1)) - 66'sd1;
    smin = -(66'sd1 <<< (ew - 1));
    umax = (66'd1 << ew) - 66'd1;
    res  = '0;
    sat  = 1'b0;
    for (int i = 0; i < ne; i++) begin
        ea   = (a >> (i * ew)) & mask;
        eb   = (b >> (i * ew)) & mask;
        ec   = (c >> (i * ew)) & mask;
        ta   = $signed(ea << (64 - ew)) >>> (64 - ew);  // Sign-extended element
        tb   = $signed(eb << (64 - ew)) >>> (64 - ew);
        sh   = eb & 64'(ew - 1);
        ssum = 66'(ta) + 66'(tb);
        usum = {2'b00, ea} + {2'b00, eb};
        r    = '0;
        case (op)
            simd_lane_pkg::OP_ADD:  r = ea + eb;
            simd_lane_pkg::OP_SUB:  r = ea - eb;
            simd_lane_pkg::OP_SADD: begin
                r = ssum[63:0];
                if (ssum > smax) begin
                    r   = smax[63:0];
                    sat = 1'b1;
                end else if (ssum < smin) begin
                    r   = smin[63:0];
                    sat = 1'b1;
                end
            end
            simd_lane_pkg::OP_SADDU: begin
                r = usum[63:0];
                if (usum > umax) begin
                    r   = umax[63:0];
                    sat = 1'b1;
                end
            end
            simd_lane_pkg::OP_MIN:  r = (ta < tb) ? ea : eb;
            simd_lane_pkg::OP_MAX:  r = (ta < tb) ? eb : ea;
            simd_lane_pkg::OP_SLL:  r = ea << sh;
            simd_lane_pkg::OP_SRL:  r = ea >> sh;
            simd_lane_pkg::OP_SRA:  r = ta >>> sh;
            simd_lane_pkg::OP_MUL:  r = ea * eb;
            simd_lane_pkg::OP_MACC: r = ea * eb + ec;
            simd_lane_pkg::OP_AND:  r = ea & eb;
            simd_lane_pkg::OP_OR:   r = ea | eb;
            simd_lane_pkg::OP_XOR:  r = ea ^ eb;
            simd_lane_pkg::OP_VID:  r = 64'(lane * ne + i);
            default:                r = '0;
        endcase
        res = res | ((r & mask) << (i * ew));
    end
    return {sat, res};
endfunction

task automatic check_result(input logic [simd_lane_pkg::DATA_W-1:0] got, exp,
                            input string what);
    if (got !== exp) begin
        abort_run($sformatf("FAILED at %0t ns: %s result %h, expected %h",
                            $time, what, got, exp));
    end
endtask

task automatic check_sat(input logic got, exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("FAILED at %0t ns: %s sat %b, expected %b", $time, what, got, exp));
    end
endtask

task automatic check_status(input logic [simd_lane_pkg::DATA_W-1:0] status,
                            input logic exp_done, exp_busy, input string what);
    logic [1:0] got;
    got = {status[simd_bus_pkg::STATUS_DONE_BIT], status[simd_bus_pkg::STATUS_BUSY_BIT]};
    if (got !== {exp_done, exp_busy}) begin
        abort_run($sformatf("FAILED at %0t ns: %s done/busy %b, expected %b",
                            $time, what, got, {exp_done, exp_busy}));
    end
endtask

task automatic wb_write(input logic [2:0] adr, input logic [63:0] data);
    int waited;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = data;
    waited   = 0;
    @(negedge clk_i);
    while (!wb_ack_o) begin
        waited++;
        if (waited >= 20) abort_run("No Wishbone ack for a write within 20 cycles");
        @(negedge clk_i);
    end
    @(negedge clk_i);                           // Write lands on the edge with ack high
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
endtask

task automatic wb_read(input logic [2:0] adr, output logic [63:0] data);
    int waited;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    waited   = 0;
    @(negedge clk_i);
    while (!wb_ack_o) begin
        waited++;
        if (waited >= 20) abort_run("No Wishbone ack for a read within 20 cycles");
        @(negedge clk_i);
    end
    data = wb_dat_o;                            // Valid while ack is high
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
endtask

function automatic logic [63:0] make_ctrl(input simd_lane_pkg::vec_op_e op,
                                          input simd_lane_pkg::sew_e sew);
    logic [63:0] ctrl;
    ctrl = '0;
    ctrl[simd_bus_pkg::CTRL_OP_LSB +: 4]  = op;
    ctrl[simd_bus_pkg::CTRL_SEW_LSB +: 2] = sew;
    ctrl[simd_bus_pkg::CTRL_START_BIT]    = 1'b1;
    return ctrl;
endfunction

function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
endfunction

task automatic start_op(input simd_lane_pkg::vec_op_e op, input simd_lane_pkg::sew_e sew,
                        input logic [63:0] a, b, c);
    wb_write(simd_bus_pkg::REG_OPA, a);
    wb_write(simd_bus_pkg::REG_OPB, b);
    wb_write(simd_bus_pkg::REG_OPC, c);
    wb_write(simd_bus_pkg::REG_CTRL, make_ctrl(op, sew));
endtask

task automatic wait_done();
    logic [63:0] status;
    int          polls;
    polls = 1;
    wb_read(simd_bus_pkg::REG_STATUS, status);
    while (!status[simd_bus_pkg::STATUS_DONE_BIT]) begin
        if (polls >= 50) abort_run("Done bit still clear after 50 status polls");
        polls++;
        wb_read(simd_bus_pkg::REG_STATUS, status);
    end
endtask

task automatic check_op(input simd_lane_pkg::vec_op_e op, input simd_lane_pkg::sew_e sew,
                        input logic [63:0] a, b, c);
    logic [63:0] result, status;
    logic [64:0] exp;
    string       what;
    what = $sformatf("op %0d sew %0d a %h b %h", op, sew, a, b);
    wait_done();
    wb_read(simd_bus_pkg::REG_RESULT, result);
    wb_read(simd_bus_pkg::REG_STATUS, status);
    exp = ref_lane(op, sew, a, b, c, LANE);
    check_result(result, exp[63:0], what);
    check_sat(status[simd_bus_pkg::STATUS_SAT_BIT], exp[64], what);
    check_status(status, 1'b1, 1'b0, what);
endtask

task automatic run_op(input simd_lane_pkg::vec_op_e op, input simd_lane_pkg::sew_e sew,
                      input logic [63:0] a, b, c);
    start_op(op, sew, a, b, c);
    check_op(op, sew, a, b, c);
endtask

task automatic run_random(input simd_lane_pkg::vec_op_e op, input simd_lane_pkg::sew_e sew,
                          input int count);
    for (int n = 0; n < count; n++) begin
        run_op(op, sew, rand64(), rand64(), rand64());
    end
endtask

initial begin
    logic [63:0]         rdata;
    logic [63:0]         a, b, c;
    simd_lane_pkg::sew_e sew;
    void'($urandom(3));
    rstn_i   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (10) @(negedge clk_i);
    rstn_i = 1'b1;
    @(negedge clk_i);

    wb_read(simd_bus_pkg::REG_RESULT, rdata);
    check_result(rdata, '0, "RESULT after reset");
    wb_read(simd_bus_pkg::REG_STATUS, rdata);
    check_result(rdata, '0, "STATUS after reset");
    wb_write(3'd7, '1);                         // Unmapped address so the write is dropped
    wb_read(3'd7, rdata);
    check_result(rdata, '0, "unmapped address 7");
    wb_read(simd_bus_pkg::REG_CTRL, rdata);
    check_result(rdata, '0, "CTRL after unmapped write");
    wb_read(simd_bus_pkg::REG_STATUS, rdata);
    check_result(rdata, '0, "STATUS after unmapped write");
    wb_read(3'd6, rdata);
    check_result(rdata, '0, "unmapped address 6");

    for (int s = 0; s < 4; s++) begin
        sew = simd_lane_pkg::sew_e'(s[1:0]);
        for (int k = 0; k < 14; k++) begin
            run_random(RAND_OPS[k], sew, (k < 4) ? 40 : 12);
        end
        // Clamp corners for the saturating adds
        run_op(simd_lane_pkg::OP_SADD, sew, 64'h7f7f7f7f7f7f7f7f, 64'h0101010101010101, '0);
        run_op(simd_lane_pkg::OP_SADD, sew, 64'h8080808080808080, 64'hfefefefefefefefe, '0);
        run_op(simd_lane_pkg::OP_SADD, sew, 64'h0102030405060708, 64'h1010101010101010, '0);
        run_op(simd_lane_pkg::OP_SADDU, sew, 64'hffffffffffffffff, 64'h0101010101010101, '0);
        run_op(simd_lane_pkg::OP_SADDU, sew, 64'h0102030405060708, 64'h1010101010101010, '0);
        run_op(simd_lane_pkg::OP_VID, sew, rand64(), rand64(), rand64());
        run_op(simd_lane_pkg::vec_op_e'(4'hf), sew, rand64(), rand64(), rand64());
    end

    // Second start lands while the MACC is still in flight
    a = rand64();
    b = rand64();
    c = rand64();
    start_op(simd_lane_pkg::OP_MACC, simd_lane_pkg::SEW_16, a, b, c);
    wb_write(simd_bus_pkg::REG_CTRL, make_ctrl(simd_lane_pkg::OP_XOR, simd_lane_pkg::SEW_8));
    check_op(simd_lane_pkg::OP_MACC, simd_lane_pkg::SEW_16, a, b, c);

    start_op(simd_lane_pkg::OP_MUL, simd_lane_pkg::SEW_32, a, b, c);
    wb_read(simd_bus_pkg::REG_STATUS, rdata);
    check_status(rdata, 1'b0, 1'b1, "status while MUL in flight");
    check_op(simd_lane_pkg::OP_MUL, simd_lane_pkg::SEW_32, a, b, c);

    $display("RESULT: PASS");
    $finish;
end

endmodule

`default_nettype wire

/* tests/simd_lane_sva.sv */
////////////////////
// Bound assertions for the SIMD lane bus slave
// Ack timing and status bit exclusion
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_lane_sva (
    input  wire clk_i,
    input  wire rstn_i,
    input  wire cyc_i,
    input  wire stb_i,
    input  wire ack_i,
    input  wire busy_i,
    input  wire done_i
);

a_ack_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
    ack_i |=> !ack_i)
    else $error("Wishbone ack held high for more than one cycle");

a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
    ack_i |-> $past(cyc_i && stb_i))
    else $error("Wishbone ack without cyc and stb in the previous cycle");

a_busy_done: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(busy_i && done_i))
    else $error("Busy and done both set");

endmodule

bind simd_lane_wb simd_lane_sva i_sva (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .cyc_i  (wb_cyc_i),
    .stb_i  (wb_stb_i),
    .ack_i  (wb_ack_o),
    .busy_i (busy_q),
    .done_i (done_q)
);

`default_nettype wire

/* verilog/simd_lane_top.sv */
////////////////////
// SIMD lane top level
// Wishbone front end plus functional unit
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_lane_top #(
    parameter int LANE_ID = 0
) (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire                                 wb_cyc_i,
    input  wire                                 wb_stb_i,
    input  wire                                 wb_we_i,
    input  wire [2:0]                           wb_adr_i,
    input  wire [simd_lane_pkg::DATA_W-1:0]     wb_dat_i,
    output logic [simd_lane_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                                wb_ack_o
);

simd_lane_pkg::vec_op_e           op;
simd_lane_pkg::sew_e              sew;
logic [simd_lane_pkg::DATA_W-1:0] opa, opb, opc, result;
logic                             sat;

simd_lane_wb i_wb (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .op_o     (op),
    .sew_o    (sew),
    .opa_o    (opa),
    .opb_o    (opb),
    .opc_o    (opc),
    .result_i (result),
    .sat_i    (sat)
);

simd_functional_unit #(
    .LANE_ID (LANE_ID)
) i_fu (
    .clk_i    (clk_i),
    .rstn_i   (rstn_i),
    .op_i     (op),
    .sew_i    (sew),
    .opa_i    (opa),
    .opb_i    (opb),
    .opc_i    (opc),
    .result_o (result),
    .sat_o    (sat)
);

endmodule

`default_nettype wire

/* verilog/simd_lane_wb.sv */
////////////////////
// Wishbone classic slave for the SIMD lane
// Register file, operation sequencing, result capture
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_lane_wb (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire                                 wb_cyc_i,
    input  wire                                 wb_stb_i,
    input  wire                                 wb_we_i,
    input  wire [2:0]                           wb_adr_i,   // Word address
    input  wire [simd_lane_pkg::DATA_W-1:0]     wb_dat_i,
    output logic [simd_lane_pkg::DATA_W-1:0]    wb_dat_o,
    output logic                                wb_ack_o,
    output simd_lane_pkg::vec_op_e              op_o,
    output simd_lane_pkg::sew_e                 sew_o,
    output logic [simd_lane_pkg::DATA_W-1:0]    opa_o,
    output logic [simd_lane_pkg::DATA_W-1:0]    opb_o,
    output logic [simd_lane_pkg::DATA_W-1:0]    opc_o,
    input  wire [simd_lane_pkg::DATA_W-1:0]     result_i,
    input  wire                                 sat_i
);

typedef enum logic [1:0] {IDLE, WAIT_MUL1, WAIT_MUL2, CAPTURE} state_e;

state_e                           state_q;
simd_bus_pkg::reg_addr_e          addr;
simd_lane_pkg::vec_op_e           start_op;
logic [simd_lane_pkg::DATA_W-1:0] result_q;
logic                             busy_q, done_q, sat_q;
logic                             wr_en, start, start_mul;

assign addr      = simd_bus_pkg::reg_addr_e'(wb_adr_i);
assign wr_en     = wb_ack_o & wb_cyc_i & wb_stb_i & wb_we_i & ~busy_q;  // Writes land with ack
assign start     = wr_en & (addr == simd_bus_pkg::REG_CTRL) &
                   wb_dat_i[simd_bus_pkg::CTRL_START_BIT];
assign start_op  = simd_lane_pkg::vec_op_e'(wb_dat_i[simd_bus_pkg::CTRL_OP_LSB +: 4]);
assign start_mul = (start_op == simd_lane_pkg::OP_MUL) || (start_op == simd_lane_pkg::OP_MACC);

always_ff @(posedge clk_i, negedge rstn_i) begin
    if (~rstn_i) begin
        wb_ack_o <= 1'b0;
        opa_o    <= '0;
        opb_o    <= '0;
        opc_o    <= '0;
        op_o     <= simd_lane_pkg::OP_ADD;
        sew_o    <= simd_lane_pkg::SEW_8;
    end else begin
        wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;    // Single cycle ack
        if (wr_en) begin
            case (addr)
                simd_bus_pkg::REG_OPA: opa_o <= wb_dat_i;
                simd_bus_pkg::REG_OPB: opb_o <= wb_dat_i;
                simd_bus_pkg::REG_OPC: opc_o <= wb_dat_i;
                simd_bus_pkg::REG_CTRL: begin
                    op_o  <= start_op;
                    sew_o <= simd_lane_pkg::sew_e'(wb_dat_i[simd_bus_pkg::CTRL_SEW_LSB +: 2]);
                end
                default: ;                              // Read-only or unmapped
            endcase
        end
    end
end

// Multiply ops wait for the product register and the staging register
always_ff @(posedge clk_i, negedge rstn_i) begin
    if (~rstn_i) begin
        state_q  <= IDLE;
        busy_q   <= 1'b0;
        done_q   <= 1'b0;
        sat_q    <= 1'b0;
        result_q <= '0;
    end else begin
        case (state_q)
            IDLE: begin
                if (start) begin
                    busy_q  <= 1'b1;
                    done_q  <= 1'b0;
                    state_q <= start_mul ? WAIT_MUL1 : CAPTURE;
                end
            end
            WAIT_MUL1: state_q <= WAIT_MUL2;
            WAIT_MUL2: state_q <= CAPTURE;
            default: begin                              // CAPTURE
                result_q <= result_i;
                sat_q    <= sat_i;
                done_q   <= 1'b1;
                busy_q   <= 1'b0;
                state_q  <= IDLE;
            end
        endcase
    end
end

always_comb begin
    wb_dat_o = '0;
    if (wb_ack_o) begin
        case (addr)
            simd_bus_pkg::REG_OPA:    wb_dat_o = opa_o;
            simd_bus_pkg::REG_OPB:    wb_dat_o = opb_o;
            simd_bus_pkg::REG_OPC:    wb_dat_o = opc_o;
            simd_bus_pkg::REG_CTRL: begin
                wb_dat_o[simd_bus_pkg::CTRL_OP_LSB +: 4]  = op_o;
                wb_dat_o[simd_bus_pkg::CTRL_SEW_LSB +: 2] = sew_o;
            end
            simd_bus_pkg::REG_RESULT: wb_dat_o = result_q;
            simd_bus_pkg::REG_STATUS: begin
                wb_dat_o[simd_bus_pkg::STATUS_DONE_BIT] = done_q;
                wb_dat_o[simd_bus_pkg::STATUS_BUSY_BIT] = busy_q;
                wb_dat_o[simd_bus_pkg::STATUS_SAT_BIT]  = sat_q;
            end
            default: ;                                  // Unmapped reads zero
        endcase
    end
end

endmodule

`default_nettype wire

/* verilog/simd_functional_unit.sv */
////////////////////
// SIMD lane functional unit
// Operand routing, product staging, bitwise ops,
// element index generation and result select
////////////////////

`timescale 1ns/1ps
`default_nettype none

module simd_functional_unit #(
    parameter int LANE_ID = 0                               // Lane number
) (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  var simd_lane_pkg::vec_op_e          op_i,
    input  var simd_lane_pkg::sew_e             sew_i,
    input  wire [simd_lane_pkg::DATA_W-1:0]     opa_i,
    input  wire [simd_lane_pkg::DATA_W-1:0]     opb_i,
    input  wire [simd_lane_pkg::DATA_W-1:0]     opc_i,      // Accumulator input
    output logic [simd_lane_pkg::DATA_W-1:0]    result_o,
    output logic                                sat_o
);

logic [simd_lane_pkg::DATA_W-1:0] add_a, add_b, sum, prod, prod_stage, shifted;
logic [simd_lane_pkg::DATA_W-1:0] vid_sew [4];
logic                             add_sat;

// Product is staged again so the accumulate add starts from a register
always_ff @(posedge clk_i, negedge rstn_i) begin
    if (~rstn_i) begin
        prod_stage <= '0;
    end else begin
        prod_stage <= prod;
    end
end

assign add_a = (op_i == simd_lane_pkg::OP_MACC) ? prod_stage : opa_i;
assign add_b = (op_i == simd_lane_pkg::OP_MACC) ? opc_i      : opb_i;

vec_addsub i_addsub (
    .op_i   (op_i),
    .sew_i  (sew_i),
    .a_i    (add_a),
    .b_i    (add_b),
    .sum_o  (sum),
    .sat_o  (add_sat)
);

vec_mul i_mul (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .sew_i  (sew_i),
    .a_i    (opa_i),
    .b_i    (opb_i),
    .prod_o (prod)
);

vec_shift i_shift (
    .op_i      (op_i),
    .sew_i     (sew_i),
    .a_i       (opa_i),
    .b_i       (opb_i),
    .shifted_o (shifted)
);

// Element e of this lane gets index LANE_ID*NE + e
for (genvar s = 0; s < 4; s++) begin : g_vid
    localparam int EW = 8 << s;
    localparam int NE = simd_lane_pkg::DATA_W / EW;
    logic [simd_lane_pkg::DATA_W-1:0] vid_v;

    for (genvar e = 0; e < NE; e++) begin : g_elem
        assign vid_v[e*EW +: EW] = EW'(LANE_ID * NE + e);
    end

    assign vid_sew[s] = vid_v;
end

always_comb begin
    sat_o = 1'b0;
    case (op_i)
        simd_lane_pkg::OP_ADD, simd_lane_pkg::OP_SUB,
        simd_lane_pkg::OP_MIN, simd_lane_pkg::OP_MAX,
        simd_lane_pkg::OP_MACC: result_o = sum;
        simd_lane_pkg::OP_SADD, simd_lane_pkg::OP_SADDU: begin
            result_o = sum;
            sat_o    = add_sat;
        end
        simd_lane_pkg::OP_SLL, simd_lane_pkg::OP_SRL,
        simd_lane_pkg::OP_SRA:  result_o = shifted;
        simd_lane_pkg::OP_MUL:  result_o = prod_stage;  // Two cycles behind operands
        simd_lane_pkg::OP_AND:  result_o = opa_i & opb_i;
        simd_lane_pkg::OP_OR:   result_o = opa_i | opb_i;
        simd_lane_pkg::OP_XOR:  result_o = opa_i ^ opb_i;
        simd_lane_pkg::OP_VID:  result_o = vid_sew[sew_i];
        default:                result_o = '0;          // Free opcode
    endcase
end

endmodule

`default_nettype wire

/* verilog/vec_shift.sv */
////////////////////
// Element-partitioned shifter
// Logical left, logical right, arithmetic right
////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_shift (
    input  var simd_lane_pkg::vec_op_e          op_i,
    input  var simd_lane_pkg::sew_e             sew_i,
    input  wire [simd_lane_pkg::DATA_W-1:0]     a_i,        // Data
    input  wire [simd_lane_pkg::DATA_W-1:0]     b_i,        // Shift amounts
    output logic [simd_lane_pkg::DATA_W-1:0]    shifted_o
);

logic [simd_lane_pkg::DATA_W-1:0] res_sew [4];

for (genvar s = 0; s < 4; s++) begin : g_sew
    localparam int EW = 8 << s;
    localparam int NE = simd_lane_pkg::DATA_W / EW;
    localparam int SW = $clog2(EW);
    logic [simd_lane_pkg::DATA_W-1:0] res_v;

    for (genvar e = 0; e < NE; e++) begin : g_elem
        logic [EW-1:0] a, res;
        logic [SW-1:0] sh;

        assign a  = a_i[e*EW +: EW];
        assign sh = b_i[e*EW +: SW];                // Low log2(SEW) bits only

        always_comb begin
            case (op_i)
                simd_lane_pkg::OP_SLL: res = a << sh;
                simd_lane_pkg::OP_SRA: res = $signed(a) >>> sh;
                default:               res = a >> sh;
            endcase
        end

        assign res_v[e*EW +: EW] = res;
    end

    assign res_sew[s] = res_v;
end

assign shifted_o = res_sew[sew_i];

endmodule

`default_nettype wire

/* verilog/vec_mul.sv */
////////////////////
// Element-partitioned low-half multiplier
// Product leaves through one register
////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_mul (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  var simd_lane_pkg::sew_e             sew_i,  // Element width
    input  wire [simd_lane_pkg::DATA_W-1:0]     a_i,
    input  wire [simd_lane_pkg::DATA_W-1:0]     b_i,
    output logic [simd_lane_pkg::DATA_W-1:0]    prod_o  // Registered product
);

logic [simd_lane_pkg::DATA_W-1:0] prod_sew [4];

for (genvar s = 0; s < 4; s++) begin : g_sew
    localparam int EW = 8 << s;
    localparam int NE = simd_lane_pkg::DATA_W / EW;
    logic [simd_lane_pkg::DATA_W-1:0] prod_v;

    for (genvar e = 0; e < NE; e++) begin : g_elem
        logic [EW-1:0] a, b;

        assign a = a_i[e*EW +: EW];
        assign b = b_i[e*EW +: EW];
        assign prod_v[e*EW +: EW] = a * b;          // Upper half dropped
    end

    assign prod_sew[s] = prod_v;
end

always_ff @(posedge clk_i, negedge rstn_i) begin
    if (~rstn_i) begin
        prod_o <= '0;
    end else begin
        prod_o <= prod_sew[sew_i];
    end
end

endmodule

`default_nettype wire

/* verilog/vec_addsub.sv */
////////////////////
// Element-partitioned add and subtract
// Saturating adds, signed minimum and maximum
////////////////////

`timescale 1ns/1ps
`default_nettype none

module vec_addsub (
    input  var simd_lane_pkg::vec_op_e          op_i,   // Operation
    input  var simd_lane_pkg::sew_e             sew_i,  // Element width
    input  wire [simd_lane_pkg::DATA_W-1:0]     a_i,    // First operand
    input  wire [simd_lane_pkg::DATA_W-1:0]     b_i,    // Second operand
    output logic [simd_lane_pkg::DATA_W-1:0]    sum_o,  // Element results
    output logic                                sat_o   // Some element clamped
);

logic [simd_lane_pkg::DATA_W-1:0] res_sew [4];
logic [3:0]                       sat_sew;

// One copy of the element logic per SEW, selected at the output
for (genvar s = 0; s < 4; s++) begin : g_sew
    localparam int EW = 8 << s;
    localparam int NE = simd_lane_pkg::DATA_W / EW;
    logic [simd_lane_pkg::DATA_W-1:0] res_v;
    logic [NE-1:0]                    sat_v;

    for (genvar e = 0; e < NE; e++) begin : g_elem
        logic [EW-1:0] a, b, sum, diff, res;
        logic          carry, ovf_add, ovf_sub, lt, sat;

        assign a = a_i[e*EW +: EW];
        assign b = b_i[e*EW +: EW];
        assign {carry, sum} = {1'b0, a} + {1'b0, b};
        assign diff = a - b;
        assign ovf_add = (a[EW-1] == b[EW-1]) && (sum[EW-1] != a[EW-1]);
        assign ovf_sub = (a[EW-1] != b[EW-1]) && (diff[EW-1] != a[EW-1]);
        assign lt = diff[EW-1] ^ ovf_sub;           // Signed a < b

        always_comb begin
            sat = 1'b0;
            case (op_i)
                simd_lane_pkg::OP_SUB: res = diff;
                simd_lane_pkg::OP_SADD: begin
                    res = ovf_add ? {a[EW-1], {(EW-1){~a[EW-1]}}} : sum;
                    sat = ovf_add;
                end
                simd_lane_pkg::OP_SADDU: begin
                    res = carry ? {EW{1'b1}} : sum;
                    sat = carry;
                end
                simd_lane_pkg::OP_MIN: res = lt ? a : b;
                simd_lane_pkg::OP_MAX: res = lt ? b : a;
                default: res = sum;                 // ADD and MACC
            endcase
        end

        assign res_v[e*EW +: EW] = res;
        assign sat_v[e] = sat;
    end

    assign res_sew[s] = res_v;
    assign sat_sew[s] = |sat_v;
end

assign sum_o = res_sew[sew_i];
assign sat_o = sat_sew[sew_i];

endmodule

`default_nettype wire

/* verilog/simd_bus_pkg.sv */
////////////////////
// Host bus definitions for the SIMD lane
// Register map and control/status bit positions
////////////////////

`default_nettype none

package simd_bus_pkg;

    typedef enum logic [2:0] {
        REG_OPA    = 3'd0,
        REG_OPB    = 3'd1,
        REG_OPC    = 3'd2,                      // Accumulate operand
        REG_CTRL   = 3'd3,
        REG_RESULT = 3'd4,
        REG_STATUS = 3'd5
    } reg_addr_e;

    localparam int CTRL_OP_LSB     = 0;         // Opcode in 3..0
    localparam int CTRL_SEW_LSB    = 4;         // SEW in 5..4
    localparam int CTRL_START_BIT  = 8;
    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_BUSY_BIT = 1;
    localparam int STATUS_SAT_BIT  = 2;

endpackage

`default_nettype wire

/* verilog/simd_lane_pkg.sv */
////////////////////
// Vector arithmetic definitions for the SIMD lane
// Lane width, element width and operation encodings
////////////////////

`default_nettype none

package simd_lane_pkg;

    localparam int DATA_W = 64;                 // Lane width in bits

    // Selected element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    // Lane operations, code 4'hF left free
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_SADD  = 4'd2,                        // Signed saturating add
        OP_SADDU = 4'd3,                        // Unsigned saturating add
        OP_MIN   = 4'd4,
        OP_MAX   = 4'd5,
        OP_SLL   = 4'd6,
        OP_SRL   = 4'd7,
        OP_SRA   = 4'd8,
        OP_MUL   = 4'd9,                        // Low half product
        OP_MACC  = 4'd10,                       // Product plus opc
        OP_AND   = 4'd11,
        OP_OR    = 4'd12,
        OP_XOR   = 4'd13,
        OP_VID   = 4'd14                        // Element index
    } vec_op_e;

endpackage

`default_nettype wire
